// ==== vld.f ====
+incdir+rtl
rtl/vld_pkg.sv
rtl/vld_insn_queue.sv
rtl/vld_beat_unpack.sv
rtl/vld_result_queue.sv
rtl/vld_top.sv
test/vld_props.sv
test/vld_checker.sv
test/vld_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector load unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vld.f --top-module vld_tb -Mdir obj_dir \
  || exit 1
out="$(./obj_dir/Vvld_tb)"
echo "$out"
echo "$out" | grep -qx "all tests passed" && exit 0 || exit 1

// ==== test/vld_tb.sv ====
// ################################################
// Vector load unit testbench
// Clock, reset, LFSR stimulus, reference words
// and the closing report
// ################################################

`timescale 1ns/1ps

module vld_tb;
  import vld_pkg::*;

  localparam int NrInsn   = 24;
  localparam int MaxBeats = NrInsn * 8;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_valid;
  logic                 req_ready;
  vid_t                 req_id;
  vreg_t                req_vd;
  vlen_t                req_vl;
  vsew_e                req_vsew;
  logic                 burst_valid;
  logic                 burst_ready;
  burst_len_t           burst_len;
  logic                 r_valid;
  logic                 r_ready;
  axi_data_t            r_data;
  logic        [1:0]    result_req;
  logic        [1:0]    result_gnt;
  vid_t        [1:0]    result_id;
  vaddr_t      [1:0]    result_addr;
  elen_t       [1:0]    result_wdata;
  strb_t       [1:0]    result_be;
  vinsn_done_t          vinsn_done;
  logic                 load_complete;

  // Generated instructions and their read beats
  vid_t      ins_id    [NrInsn];
  vreg_t     ins_vd    [NrInsn];
  vlen_t     ins_vl    [NrInsn];
  logic [1:0] ins_sew  [NrInsn];
  int        ins_base  [NrInsn];
  int        ins_beats [NrInsn];
  axi_data_t beats     [MaxBeats];
  int        total_beats;

  // Progress seen at the rising edge
  int   accepted;
  int   bursts_done;
  int   beats_done;
  logic full_seen;
  logic started;
  logic grant_en;
  int   tb_errors;
  int   timeouts;
  int   chk_errors;
  int   completed;
  logic [31:0] lfsr_q;
  logic [2:0]  draws;

  vld_top dut0 (
    .clk_i, .rst_ni,
    .req_valid_i (req_valid), .req_id_i (req_id), .req_vd_i (req_vd),
    .req_vl_i (req_vl), .req_vsew_i (req_vsew), .req_ready_o (req_ready),
    .burst_valid_i (burst_valid), .burst_len_i (burst_len), .burst_ready_o (burst_ready),
    .r_valid_i (r_valid), .r_data_i (r_data), .r_ready_o (r_ready),
    .result_req_o (result_req), .result_id_o (result_id), .result_addr_o (result_addr),
    .result_wdata_o (result_wdata), .result_be_o (result_be), .result_gnt_i (result_gnt),
    .vinsn_done_o (vinsn_done), .load_complete_o (load_complete)
  );

  vld_checker chk0 (
    .clk_i, .rst_ni,
    .result_req_i (result_req), .result_gnt_i (result_gnt), .result_id_i (result_id),
    .result_addr_i (result_addr), .result_wdata_i (result_wdata), .result_be_i (result_be),
    .vinsn_done_i (vinsn_done), .load_complete_i (load_complete),
    .errors_o (chk_errors), .completed_o (completed)
  );

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Ids stay unique among the instructions that can be in flight together
  function automatic logic id_clash(input int n, input vid_t id);
    for (int j = (n > 4 ? n - 4 : 0); j < n; j++) begin
      if (ins_id[j] == id) return 1'b1;
    end
    return 1'b0;
  endfunction

  // Word w of instruction n as {strobes, data}: element i of the word goes to
  // lane i mod 2, row i div 2 of that lane
  function automatic logic [143:0] ref_word(input int n, input int w);
    logic [127:0] data;
    logic [15:0]  be;
    int           size;
    int           g;
    int           i;
    int           d;
    data = '0;
    be   = '0;
    size = 1 << ins_sew[n];
    for (int s = 0; s < 16; s++) begin
      g = 16 * w + s;
      if (g < int'(ins_vl[n]) * size) begin
        i = s / size;
        d = (i % 2) * 8 + (i / 2) * size + s % size;
        data[8*d +: 8] = beats[ins_base[n] + g / 8][8*(g % 8) +: 8];
        be[d]          = 1'b1;
      end
    end
    return {be, data};
  endfunction

  task automatic check_out(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      tb_errors++;
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // All inputs change on the falling edge, random draws in fixed order
  always @(negedge clk_i) begin
    draws      = 3'(rand_bits(3));
    req_valid  = started && accepted < NrInsn && draws[0];
    if (accepted < NrInsn) begin
      req_id   = ins_id[accepted];
      req_vd   = ins_vd[accepted];
      req_vl   = ins_vl[accepted];
      req_vsew = vsew_e'(ins_sew[accepted]);
    end
    burst_valid = started && bursts_done < NrInsn;
    if (bursts_done < NrInsn) begin
      burst_len = burst_len_t'(ins_beats[bursts_done] - 1);
    end
    r_valid = started && beats_done < total_beats && draws[2:1] != 2'b00;
    if (beats_done < total_beats) begin
      r_data = beats[beats_done];
    end
    for (int l = 0; l < 2; l++) begin
      result_gnt[l] = grant_en && result_req[l] && (rand_bits(2) != 0);
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && started) begin
      // Ready drops at four pending loads while grants are withheld
      if (!grant_en) begin
        check_out("req_ready_o", 64'(req_ready), 64'(accepted < 4));
      end
      if (req_valid && req_ready) accepted++;
      if (burst_ready) bursts_done++;
      if (r_valid && r_ready) beats_done++;
      if (!req_ready) full_seen = 1'b1;
    end
  end

  initial begin
    logic [143:0] r;
    vid_t         id;
    int           bytes;
    int           cnt;
    rst_ni = 1'b1;
    lfsr_q = 32'h4ede3d4f;
    {req_valid, burst_valid, r_valid, result_gnt} = '0;
    {req_id, req_vd, req_vl, burst_len, r_data} = '0;
    req_vsew = EW8;
    {accepted, bursts_done, beats_done, tb_errors, timeouts, total_beats} = '0;
    {full_seen, started, grant_en} = '0;

    // Instructions, beats and the expected stream; each width appears first
    for (int n = 0; n < NrInsn; n++) begin
      ins_sew[n] = (n < 4) ? 2'(n) : 2'(rand_bits(2));
      ins_vl[n]  = vlen_t'(1 + rand_bits(7) % (64 >> ins_sew[n]));
      ins_vd[n]  = vreg_t'(rand_bits(5));
      id         = vid_t'(rand_bits(3));
      for (int t = 0; t < 8 && id_clash(n, id); t++) id++;
      ins_id[n]    = id;
      bytes        = int'(ins_vl[n]) << ins_sew[n];
      ins_beats[n] = (bytes + 7) / 8;
      ins_base[n]  = total_beats;
      for (int k = 0; k < ins_beats[n]; k++) begin
        beats[total_beats + k] = {rand_bits(32), rand_bits(32)};
      end
      total_beats += ins_beats[n];
      for (int w = 0; w < (bytes + 15) / 16; w++) begin
        r = ref_word(n, w);
        for (int l = 0; l < 2; l++) begin
          chk0.expect_word(l, {16'(n), id, 7'(ins_vd[n] * 4 + w), r[64*l +: 64],
                               r[128 + 8*l +: 8]});
        end
      end
      chk0.expect_done(n, id);
    end

    #1 rst_ni = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_out("req_ready_o", 64'(req_ready), 64'h1);
    check_out("r_ready_o", 64'(r_ready), 64'h0);
    check_out("burst_ready_o", 64'(burst_ready), 64'h0);
    check_out("result_req_o", 64'(result_req), 64'h0);
    check_out("vinsn_done_o", 64'(vinsn_done), 64'h0);
    check_out("load_complete_o", 64'(load_complete), 64'h0);
    started = 1'b1;

    // Grants withheld until four pending instructions stop the sequencer
    cnt = 0;
    while (!full_seen && cnt < 500) begin
      @(posedge clk_i);
      cnt++;
    end
    if (!full_seen) begin
      timeouts++;
      $display("req_ready_o never dropped while grants were withheld");
    end
    grant_en = 1'b1;

    cnt = 0;
    while (completed < NrInsn && cnt < 20000) begin
      @(posedge clk_i);
      cnt++;
    end
    if (completed < NrInsn) begin
      timeouts++;
      $display("timed out with %0d of %0d loads complete", completed, NrInsn);
    end
    repeat (3) @(posedge clk_i);
    if (chk0.pending() != 0) begin
      tb_errors++;
      $display("%0d expected words or completions never seen", chk0.pending());
    end

    $display("checker errors %0d, testbench errors %0d, timeouts %0d",
             chk_errors, tb_errors, timeouts);
    if (chk_errors == 0 && tb_errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== test/vld_checker.sv ====
// ################################################
// Lane write and completion monitor
// Compares granted writes and done pulses with the
// expected stream loaded by the testbench
// ################################################

`timescale 1ns/1ps

module vld_checker (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                   [1:0] result_req_i,
  input  logic                   [1:0] result_gnt_i,
  input  vld_pkg::vid_t          [1:0] result_id_i,
  input  vld_pkg::vaddr_t        [1:0] result_addr_i,
  input  vld_pkg::elen_t         [1:0] result_wdata_i,
  input  vld_pkg::strb_t         [1:0] result_be_i,
  input  vld_pkg::vinsn_done_t         vinsn_done_i,
  input  logic                         load_complete_i,
  output int                           errors_o,
  output int                           completed_o
);
  import vld_pkg::*;

  // Entry {insn[97:82], id[81:79], addr[78:72], data[71:8], be[7:0]}
  logic [97:0] lane_q [2][$];
  // Completions in acceptance order {insn, id}
  logic [18:0] done_q [$];
  vinsn_done_t done_exp;
  logic [97:0] e;
  logic [18:0] c;

  task automatic expect_word(input int lane, input logic [97:0] entry);
    lane_q[lane].push_back(entry);
  endtask

  task automatic expect_done(input int insn, input vid_t id);
    done_q.push_back({16'(insn), id});
  endtask

  function automatic int pending();
    return lane_q[0].size() + lane_q[1].size() + done_q.size();
  endfunction

  task automatic compare(input string name, input int lane, input logic [63:0] got,
                         input logic [63:0] exp);
    if (got !== exp) begin
      errors_o++;
      $display("ERR %s[%0d] got 0x%0h expected 0x%0h", name, lane, got, exp);
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      errors_o    = 0;
      completed_o = 0;
      done_exp    = '0;
    end else begin
      for (int l = 0; l < 2; l++) begin
        if (result_req_i[l] && result_gnt_i[l]) begin
          if (lane_q[l].size() == 0) begin
            errors_o++;
            $display("lane %0d wrote a word that was never expected", l);
          end else begin
            e = lane_q[l].pop_front();
            compare("result_id_o", l, 64'(result_id_i[l]), 64'(e[81:79]));
            compare("result_addr_o", l, 64'(result_addr_i[l]), 64'(e[78:72]));
            compare("result_wdata_o", l, result_wdata_i[l], e[71:8]);
            compare("result_be_o", l, 64'(result_be_i[l]), 64'(e[7:0]));
          end
        end
      end
      // Done vector lags the completion pulse by one cycle
      compare("vinsn_done_o", 0, 64'(vinsn_done_i), 64'(done_exp));
      done_exp = '0;
      if (load_complete_i) begin
        if (done_q.size() == 0) begin
          errors_o++;
          $display("load completed with no instruction outstanding");
        end else begin
          c = done_q.pop_front();
          for (int l = 0; l < 2; l++) begin
            if (lane_q[l].size() != 0 && lane_q[l][0][97:82] == c[18:3]) begin
              errors_o++;
              $display("instruction %0d completed before lane %0d took its words", c[18:3], l);
            end
          end
          done_exp[c[2:0]] = 1'b1;
          completed_o++;
        end
      end
    end
  end

endmodule

// ==== test/vld_props.sv ====
// ################################################
// Bound assertions for the vector load unit
// Lane request hold, completion timing, reset state
// ################################################

`timescale 1ns/1ps

module vld_props (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 req_ready_o,
  input logic                 r_ready_o,
  input logic                 burst_ready_o,
  input logic                 load_complete_o,
  input logic [1:0]           result_req_o,
  input logic [1:0]           result_gnt_i,
  input vld_pkg::vinsn_done_t vinsn_done_o
);

  for (genvar l = 0; l < 2; l++) begin : g_lane
    // Request holds until the lane grants it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] && !result_gnt_i[l] |=> result_req_o[l])
      else $error("lane %0d request dropped without a grant", l);
  end

  // Completion only in a cycle where every open lane request is granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_complete_o |-> (result_req_o & ~result_gnt_i) == '0)
    else $error("load completed while a lane write was still open");

  // Idle outputs while reset is held
  assert property (@(posedge clk_i) !rst_ni |-> req_ready_o && !r_ready_o && !burst_ready_o
    && result_req_o == '0 && vinsn_done_o == '0 && !load_complete_o)
    else $error("outputs not idle in reset");

endmodule

bind vld_top vld_props props0 (
  .clk_i, .rst_ni, .req_ready_o, .r_ready_o, .burst_ready_o, .load_complete_o,
  .result_req_o, .result_gnt_i, .vinsn_done_o
);

// ==== rtl/vld_top.sv ====
// ################################################
// Vector load unit top level
// Instruction queue, beat unpacker, result queue
// ################################################

`timescale 1ns/1ps
`include "vld_params.svh"

module vld_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_valid_i,
  input  vld_pkg::vid_t                       req_id_i,
  input  vld_pkg::vreg_t                      req_vd_i,
  input  vld_pkg::vlen_t                      req_vl_i,
  input  vld_pkg::vsew_e                      req_vsew_i,
  output logic                                req_ready_o,
  input  logic                                burst_valid_i,
  input  vld_pkg::burst_len_t                 burst_len_i,
  output logic                                burst_ready_o,
  input  logic                                r_valid_i,
  input  vld_pkg::axi_data_t                  r_data_i,
  output logic                                r_ready_o,
  output logic            [`VLD_NR_LANES-1:0] result_req_o,
  output vld_pkg::vid_t   [`VLD_NR_LANES-1:0] result_id_o,
  output vld_pkg::vaddr_t [`VLD_NR_LANES-1:0] result_addr_o,
  output vld_pkg::elen_t  [`VLD_NR_LANES-1:0] result_wdata_o,
  output vld_pkg::strb_t  [`VLD_NR_LANES-1:0] result_be_o,
  input  logic            [`VLD_NR_LANES-1:0] result_gnt_i,
  output vld_pkg::vinsn_done_t                vinsn_done_o,
  output logic                                load_complete_o
);
  import vld_pkg::*;

  // Head of the issue phase
  logic  issue_valid;
  vid_t  issue_id;
  vreg_t issue_vd;
  vsew_e issue_vsew;
  vlen_t issue_vl;
  vlen_t issue_remaining;

  // Finished word toward the result queue
  logic                         word_push;
  vid_t                         word_id;
  vaddr_t                       word_addr;
  elen_t [`VLD_NR_LANES-1:0]    word_data;
  strb_t [`VLD_NR_LANES-1:0]    word_be;
  logic                         queue_full;
  logic                         retire;

  vld_insn_queue u_insn_queue (
    .clk_i, .rst_ni,
    .req_valid_i, .req_id_i, .req_vd_i, .req_vl_i, .req_vsew_i, .req_ready_o,
    .word_push_i       (word_push),
    .retire_i          (retire),
    .issue_valid_o     (issue_valid),
    .issue_id_o        (issue_id),
    .issue_vd_o        (issue_vd),
    .issue_vsew_o      (issue_vsew),
    .issue_vl_o        (issue_vl),
    .issue_remaining_o (issue_remaining),
    .vinsn_done_o, .load_complete_o
  );

  vld_beat_unpack u_beat_unpack (
    .clk_i, .rst_ni,
    .issue_valid_i     (issue_valid),
    .issue_id_i        (issue_id),
    .issue_vd_i        (issue_vd),
    .issue_vsew_i      (issue_vsew),
    .issue_vl_i        (issue_vl),
    .issue_remaining_i (issue_remaining),
    .burst_valid_i, .burst_len_i, .r_valid_i, .r_data_i,
    .queue_full_i      (queue_full),
    .r_ready_o, .burst_ready_o,
    .word_push_o       (word_push),
    .word_id_o         (word_id),
    .word_addr_o       (word_addr),
    .word_data_o       (word_data),
    .word_be_o         (word_be)
  );

  vld_result_queue u_result_queue (
    .clk_i, .rst_ni,
    .push_i      (word_push),
    .push_id_i   (word_id),
    .push_addr_i (word_addr),
    .push_data_i (word_data),
    .push_be_i   (word_be),
    .result_gnt_i,
    .full_o      (queue_full),
    .retire_o    (retire),
    .result_req_o, .result_id_o, .result_addr_o, .result_wdata_o, .result_be_o
  );

endmodule

// ==== rtl/vld_result_queue.sv ====
// ################################################
// Result queue
// Per-lane valid bits with request/grant, entries
// retire once every lane has taken its part
// ################################################

`timescale 1ns/1ps
`include "vld_params.svh"

module vld_result_queue (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                push_i,
  input  vld_pkg::vid_t                       push_id_i,
  input  vld_pkg::vaddr_t                     push_addr_i,
  input  vld_pkg::elen_t  [`VLD_NR_LANES-1:0] push_data_i,
  input  vld_pkg::strb_t  [`VLD_NR_LANES-1:0] push_be_i,
  input  logic            [`VLD_NR_LANES-1:0] result_gnt_i,
  output logic                                full_o,
  output logic                                retire_o,
  output logic            [`VLD_NR_LANES-1:0] result_req_o,
  output vld_pkg::vid_t   [`VLD_NR_LANES-1:0] result_id_o,
  output vld_pkg::vaddr_t [`VLD_NR_LANES-1:0] result_addr_o,
  output vld_pkg::elen_t  [`VLD_NR_LANES-1:0] result_wdata_o,
  output vld_pkg::strb_t  [`VLD_NR_LANES-1:0] result_be_o
);
  import vld_pkg::*;

  localparam int unsigned Depth    = `VLD_RESULT_DEPTH;
  localparam int unsigned NrLanes  = `VLD_NR_LANES;
  localparam int unsigned PntWidth = $clog2(Depth);

  // Entry payload, one copy per lane
  vid_t   id_q    [Depth][NrLanes];
  vaddr_t addr_q  [Depth][NrLanes];
  elen_t  wdata_q [Depth][NrLanes];
  strb_t  be_q    [Depth][NrLanes];

  // Lanes still to be served per entry
  logic [NrLanes-1:0]  valid_q [Depth];
  logic [NrLanes-1:0]  valid_d [Depth];
  logic [PntWidth-1:0] wr_pnt_q, rd_pnt_q;
  logic [PntWidth:0]   cnt_q;

  assign full_o = (cnt_q == (PntWidth+1)'(Depth));

  // Lanes always see the oldest entry
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      result_req_o[l]   = valid_q[rd_pnt_q][l];
      result_id_o[l]    = id_q[rd_pnt_q][l];
      result_addr_o[l]  = addr_q[rd_pnt_q][l];
      result_wdata_o[l] = wdata_q[rd_pnt_q][l];
      result_be_o[l]    = be_q[rd_pnt_q][l];
    end
  end

  always_comb begin
    valid_d = valid_q;
    // A grant serves that lane only
    for (int l = 0; l < NrLanes; l++) begin
      if (result_gnt_i[l]) begin
        valid_d[rd_pnt_q][l] = 1'b0;
      end
    end
    // Retire once no lane of the head entry is left
    retire_o = (cnt_q != '0) && (valid_d[rd_pnt_q] == '0);
    if (push_i) begin
      valid_d[wr_pnt_q] = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int e = 0; e < Depth; e++) begin
        valid_q[e] <= '0;
      end
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      if (push_i) begin
        wr_pnt_q <= (wr_pnt_q == PntWidth'(Depth - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (retire_o) begin
        rd_pnt_q <= (rd_pnt_q == PntWidth'(Depth - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + (PntWidth+1)'(push_i) - (PntWidth+1)'(retire_o);
    end
  end

  // Payload is cleared on grant and written on push
  always_ff @(posedge clk_i) begin
    for (int l = 0; l < NrLanes; l++) begin
      if (result_gnt_i[l]) begin
        id_q[rd_pnt_q][l]    <= '0;
        addr_q[rd_pnt_q][l]  <= '0;
        wdata_q[rd_pnt_q][l] <= '0;
        be_q[rd_pnt_q][l]    <= '0;
      end
      if (push_i) begin
        id_q[wr_pnt_q][l]    <= push_id_i;
        addr_q[wr_pnt_q][l]  <= push_addr_i;
        wdata_q[wr_pnt_q][l] <= push_data_i[l];
        be_q[wr_pnt_q][l]    <= push_be_i[l];
      end
    end
  end

endmodule

// ==== rtl/vld_beat_unpack.sv ====
// ################################################
// Read beat unpacker
// Burst beat counter, byte pointer into the word,
// element-width shuffle and lane word address
// ################################################

`timescale 1ns/1ps
`include "vld_params.svh"

module vld_beat_unpack (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      issue_valid_i,
  input  vld_pkg::vid_t                             issue_id_i,
  input  vld_pkg::vreg_t                            issue_vd_i,
  input  vld_pkg::vsew_e                            issue_vsew_i,
  input  vld_pkg::vlen_t                            issue_vl_i,
  input  vld_pkg::vlen_t                            issue_remaining_i,
  input  logic                                      burst_valid_i,
  input  vld_pkg::burst_len_t                       burst_len_i,
  input  logic                                      r_valid_i,
  input  vld_pkg::axi_data_t                        r_data_i,
  input  logic                                      queue_full_i,
  output logic                                      r_ready_o,
  output logic                                      burst_ready_o,
  output logic                                      word_push_o,
  output vld_pkg::vid_t                             word_id_o,
  output vld_pkg::vaddr_t                           word_addr_o,
  output vld_pkg::elen_t [`VLD_NR_LANES-1:0]        word_data_o,
  output vld_pkg::strb_t [`VLD_NR_LANES-1:0]        word_be_o
);
  import vld_pkg::*;

  localparam int unsigned NrLanes   = `VLD_NR_LANES;
  localparam int unsigned LaneBytes = `VLD_ELEN / 8;
  localparam int unsigned BeatBytes = `VLD_AXI_DW / 8;
  localparam int unsigned WordBytes = NrLanes * LaneBytes;
  localparam int unsigned WordShift = $clog2(WordBytes);

  // Beats taken from the current burst
  burst_len_t           len_q, len_d;
  // Next free sequential byte of the word being built
  logic [WordShift:0]   vrf_pnt_q, vrf_pnt_d;
  // Bytes of the word gathered from earlier beats
  elen_t [NrLanes-1:0]  stage_data_q;
  strb_t [NrLanes-1:0]  stage_be_q;
  logic                 beat;
  logic [9:0]           rem_bytes;
  vlen_t                words_issued;

  // Ready only with an instruction, its burst and room for a word
  assign r_ready_o = issue_valid_i && burst_valid_i && !queue_full_i;
  assign beat      = r_ready_o && r_valid_i;

  // Bytes still owed by the instruction, from the start of this word
  assign rem_bytes = 10'(issue_remaining_i) << issue_vsew_i;

  // Lane word address of the word under construction
  assign words_issued = (issue_vl_i - issue_remaining_i) >> (WordShift - int'(issue_vsew_i));
  assign word_id_o    = issue_id_i;
  assign word_addr_o  = vaddr_t'(issue_vd_i * `VLD_WORDS_PER_VREG + words_issued);

  always_comb begin
    logic [WordShift:0] seq;
    logic [3:0]         idx;
    len_d         = len_q;
    vrf_pnt_d     = vrf_pnt_q;
    burst_ready_o = 1'b0;
    word_push_o   = 1'b0;
    seq           = '0;
    idx           = '0;

    // Start from the staged bytes, zero where nothing was written
    word_be_o = stage_be_q;
    for (int l = 0; l < NrLanes; l++) begin
      for (int b = 0; b < LaneBytes; b++) begin
        word_data_o[l][8*b +: 8] = stage_be_q[l][b] ? stage_data_q[l][8*b +: 8] : 8'h00;
      end
    end

    if (beat) begin
      // Bytes past the instruction's last element are dropped
      for (int b = 0; b < BeatBytes; b++) begin
        seq = vrf_pnt_q + (WordShift+1)'(b);
        if (10'(seq) < rem_bytes) begin
          idx = shuffle_index(seq[3:0], issue_vsew_i);
          word_data_o[idx / LaneBytes][8*(idx % LaneBytes) +: 8] = r_data_i[8*b +: 8];
          word_be_o[idx / LaneBytes][idx % LaneBytes]            = 1'b1;
        end
      end

      // Word complete when full or when the instruction runs out
      vrf_pnt_d = vrf_pnt_q + (WordShift+1)'(BeatBytes);
      if (vrf_pnt_d == (WordShift+1)'(WordBytes) || 10'(vrf_pnt_d) >= rem_bytes) begin
        word_push_o = 1'b1;
        vrf_pnt_d   = '0;
      end

      // Last beat of the burst releases the descriptor
      if (len_q == burst_len_i) begin
        burst_ready_o = 1'b1;
        len_d         = '0;
      end else begin
        len_d = len_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      len_q      <= '0;
      vrf_pnt_q  <= '0;
      stage_be_q <= '0;
    end else begin
      len_q     <= len_d;
      vrf_pnt_q <= vrf_pnt_d;
      if (beat) begin
        stage_be_q <= word_push_o ? '0 : word_be_o;
      end
    end
  end

  // Partial word payload
  always_ff @(posedge clk_i) begin
    if (beat) begin
      stage_data_q <= word_data_o;
    end
  end

endmodule

// ==== rtl/vld_insn_queue.sv ====
// ################################################
// Load instruction queue
// Accept/issue/commit pointers, element counters,
// done vector and load-complete pulse
// ################################################

`timescale 1ns/1ps
`include "vld_params.svh"

module vld_insn_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  input  vld_pkg::vid_t        req_id_i,
  input  vld_pkg::vreg_t       req_vd_i,
  input  vld_pkg::vlen_t       req_vl_i,
  input  vld_pkg::vsew_e       req_vsew_i,
  output logic                 req_ready_o,
  input  logic                 word_push_i,
  input  logic                 retire_i,
  output logic                 issue_valid_o,
  output vld_pkg::vid_t        issue_id_o,
  output vld_pkg::vreg_t       issue_vd_o,
  output vld_pkg::vsew_e       issue_vsew_o,
  output vld_pkg::vlen_t       issue_vl_o,
  output vld_pkg::vlen_t       issue_remaining_o,
  output vld_pkg::vinsn_done_t vinsn_done_o,
  output logic                 load_complete_o
);
  import vld_pkg::*;

  localparam int unsigned Depth     = `VLD_INSN_DEPTH;
  localparam int unsigned PntWidth  = $clog2(Depth);
  localparam int unsigned WordBytes = `VLD_NR_LANES * `VLD_ELEN / 8;

  // Instruction storage
  vid_t  id_q   [Depth];
  vreg_t vd_q   [Depth];
  vlen_t vl_q   [Depth];
  vsew_e vsew_q [Depth];

  // Queue pointers and instructions waiting per phase
  logic [PntWidth-1:0] accept_pnt_q;
  logic [PntWidth-1:0] issue_pnt_q, issue_pnt_d;
  logic [PntWidth-1:0] commit_pnt_q, commit_pnt_d;
  logic [PntWidth:0]   issue_cnt_q, issue_cnt_d;
  logic [PntWidth:0]   commit_cnt_q, commit_cnt_d;

  // Elements left in the head instruction of each phase
  vlen_t       issue_rem_q, issue_rem_d;
  vlen_t       commit_rem_q, commit_rem_d;
  vinsn_done_t done_d;
  logic        accept;

  // One word holds 16 bytes across both lanes
  function automatic vlen_t sub_word(input vlen_t cnt, input vsew_e vsew);
    vlen_t step;
    step = vlen_t'(WordBytes >> vsew);
    return (cnt > step) ? cnt - step : '0;
  endfunction

  // Full when every slot waits for commit
  assign req_ready_o = (commit_cnt_q != (PntWidth+1)'(Depth));
  assign accept      = req_valid_i && req_ready_o;

  assign issue_valid_o     = (issue_cnt_q != '0);
  assign issue_id_o        = id_q[issue_pnt_q];
  assign issue_vd_o        = vd_q[issue_pnt_q];
  assign issue_vsew_o      = vsew_q[issue_pnt_q];
  assign issue_vl_o        = vl_q[issue_pnt_q];
  assign issue_remaining_o = issue_rem_q;

  always_comb begin
    issue_pnt_d     = issue_pnt_q;
    issue_cnt_d     = issue_cnt_q;
    issue_rem_d     = issue_rem_q;
    commit_pnt_d    = commit_pnt_q;
    commit_cnt_d    = commit_cnt_q;
    commit_rem_d    = commit_rem_q;
    done_d          = '0;
    load_complete_o = 1'b0;

    // Word sent to the result queue
    if (word_push_i) begin
      issue_rem_d = sub_word(issue_rem_q, vsew_q[issue_pnt_q]);
    end
    // Last word issued, move on to the next instruction
    if (issue_valid_o && issue_rem_d == '0) begin
      issue_cnt_d = issue_cnt_q - 1'b1;
      issue_pnt_d = issue_pnt_q + 1'b1;
      if (issue_cnt_d != '0) begin
        issue_rem_d = vl_q[issue_pnt_d];
      end
    end

    // Word written by every lane
    if (retire_i) begin
      commit_rem_d = sub_word(commit_rem_q, vsew_q[commit_pnt_q]);
    end
    // Last word committed, report the instruction
    if (commit_cnt_q != '0 && commit_rem_d == '0) begin
      load_complete_o            = 1'b1;
      done_d[id_q[commit_pnt_q]] = 1'b1;
      commit_cnt_d               = commit_cnt_q - 1'b1;
      commit_pnt_d               = commit_pnt_q + 1'b1;
      if (commit_cnt_d != '0) begin
        commit_rem_d = vl_q[commit_pnt_d];
      end
    end

    // A new instruction becomes the head of an empty phase
    if (accept) begin
      if (issue_cnt_d == '0) begin
        issue_rem_d = req_vl_i;
      end
      if (commit_cnt_d == '0) begin
        commit_rem_d = req_vl_i;
      end
      issue_cnt_d  = issue_cnt_d + 1'b1;
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      issue_rem_q  <= '0;
      commit_rem_q <= '0;
      vinsn_done_o <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      issue_pnt_q  <= issue_pnt_d;
      commit_pnt_q <= commit_pnt_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      issue_rem_q  <= issue_rem_d;
      commit_rem_q <= commit_rem_d;
      vinsn_done_o <= done_d;
    end
  end

  // Instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q[accept_pnt_q]   <= req_id_i;
      vd_q[accept_pnt_q]   <= req_vd_i;
      vl_q[accept_pnt_q]   <= req_vl_i;
      vsew_q[accept_pnt_q] <= req_vsew_i;
    end
  end

endmodule

// ==== rtl/vld_pkg.sv ====
// ################################################
// Vector load unit package
// Data and instruction field types, element width
// and the memory-to-lane byte shuffle
// ################################################

`include "vld_params.svh"

package vld_pkg;

  // Data path words
  typedef logic [`VLD_ELEN-1:0]   elen_t;
  typedef logic [`VLD_ELEN/8-1:0] strb_t;
  typedef logic [`VLD_AXI_DW-1:0] axi_data_t;

  // Instruction fields
  typedef logic [$clog2(`VLD_NR_VINSN)-1:0] vid_t;
  typedef logic [4:0]                       vreg_t;
  typedef logic [6:0]                       vlen_t;
  typedef logic [6:0]                       vaddr_t;
  typedef logic [7:0]                       burst_len_t;
  typedef logic [`VLD_NR_VINSN-1:0]         vinsn_done_t;

  // Log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  // Consecutive elements alternate between lanes, so a sequential byte
  // of the word lands at lane * 8 + element row * size + byte in element
  function automatic logic [3:0] shuffle_index(input logic [3:0] seq_byte, input vsew_e vsew);
    int unsigned elem;
    int unsigned byte_in_elem;
    int unsigned shuffled;
    elem         = int'(seq_byte) >> vsew;
    byte_in_elem = int'(seq_byte) & ((1 << vsew) - 1);
    shuffled     = (elem % `VLD_NR_LANES) * (`VLD_ELEN / 8)
                 + ((elem / `VLD_NR_LANES) << vsew) + byte_in_elem;
    return shuffled[3:0];
  endfunction

endpackage

// ==== rtl/vld_params.svh ====
// ################################################
// Vector load unit configuration
// Lane count, data widths and queue depths
// ################################################

`ifndef VLD_PARAMS_SVH
`define VLD_PARAMS_SVH

// Lanes sharing one vector register word
`define VLD_NR_LANES 2
// Lane word and read beat widths in bits
`define VLD_ELEN 64
`define VLD_AXI_DW 64

// Pending load instructions and buffered result words
`define VLD_INSN_DEPTH 4
`define VLD_RESULT_DEPTH 2

// Lane words per vector register (VLEN 512), number of instruction ids
`define VLD_WORDS_PER_VREG 4
`define VLD_NR_VINSN 8

`endif
